//--- hw/bus_pkg.sv
package bus_pkg;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        wr;
   } bus_req_t;

   typedef struct packed {
      logic [7:0] data;
   } bus_rsp_t;

   // address map
   localparam int          RAM_AW        = 12;       // 4 KiB
   localparam logic [15:0] RAM_TOP       = 16'h0FFF;
   localparam logic [7:0]  SYS_PAGE      = 8'h93;    // 0x93xx register page
   localparam logic [7:0]  UNMAPPED_DATA = 8'hFF;

endpackage

//--- hw/sysctl_pkg.sv
package sysctl_pkg;

   typedef struct packed {
      logic [7:0] offset;
      logic [7:0] wdata;
      logic       wr;
   } reg_access_t;

   // register page offsets
   localparam logic [7:0] REG_SPEED      = 8'h00;
   localparam logic [7:0] REG_TIMER_IDX  = 8'h01;
   localparam logic [7:0] REG_TICKS_LO   = 8'h02;
   localparam logic [7:0] REG_TICKS_MID  = 8'h03;
   localparam logic [7:0] REG_TICKS_HI   = 8'h04;
   localparam logic [7:0] REG_TIMER_LOAD = 8'h05;
   localparam logic [7:0] REG_TIMER_EN   = 8'h06;
   localparam logic [7:0] REG_IRQ        = 8'h07;  // write acks, read gives irq byte
   localparam logic [7:0] REG_STATUS     = 8'h08;
   localparam logic [7:0] REG_UART_DATA  = 8'h09;

   localparam int NUM_TIMERS = 8;
   localparam int TIMER_W    = 20;

   typedef logic [TIMER_W-1:0] timer_val_t;

   localparam int UART_DIV = 8;  // sys_clk cycles per bit

endpackage

//--- hw/interval_timer.sv
`timescale 1ns/1ps

module interval_timer
   import sysctl_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       enable,
   input  logic       load,
   input  logic       ack,
   input  timer_val_t max_ticks,
   output timer_val_t value,
   output logic       irq
);

   timer_val_t count;
   timer_val_t max_q;
   logic       wrap;

   assign wrap  = enable && !load && (count == max_q);
   assign value = count;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         count <= '0;
         max_q <= '0;
      end else if (load) begin
         max_q <= max_ticks;
         count <= '0;
      end else if (enable) begin
         if (wrap)
            count <= '0;
         else
            count <= count + 1'b1;
      end
   end

   // wrap wins over ack
   always_ff @(posedge sys_clk) begin
      if (!reset_n)
         irq <= 1'b0;
      else if (wrap)
         irq <= 1'b1;
      else if (ack)
         irq <= 1'b0;
   end

endmodule

//--- hw/clk_throttle.sv
`timescale 1ns/1ps

module clk_throttle (
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic [2:0] speed,
   output logic       clk_en
);

   logic [4:0] counter;
   logic [2:0] speed_q;
   logic [4:0] cur_mask;
   logic       cur_hit;

   // low counter bits that must be zero for a pulse
   function automatic logic [4:0] speed_mask(input logic [2:0] s);
      logic [4:0] m;
      case (s)
         3'd0:    m = 5'b00000;
         3'd1:    m = 5'b00001;
         3'd2:    m = 5'b00011;
         3'd3:    m = 5'b00111;
         3'd4:    m = 5'b01111;
         default: m = 5'b11111;  // 5..7 capped at /32
      endcase
      return m;
   endfunction

   assign cur_mask = speed_mask(speed_q);
   assign cur_hit  = ((counter & cur_mask) == 5'd0);
   assign clk_en   = cur_hit;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         counter <= '0;
         speed_q <= '0;
      end else begin
         counter <= counter + 1'b1;
         if (cur_hit)
            speed_q <= speed;  // switch on an old-period boundary
      end
   end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
   import sysctl_pkg::*;
(
   input  logic       sys_clk,
   input  logic       reset_n,
   input  logic       wr_en,
   input  logic [7:0] wr_data,
   output logic       busy,
   output logic       tx
);

   logic [9:0]                  shift;
   logic [3:0]                  bit_cnt;
   logic [$clog2(UART_DIV)-1:0] div_cnt;
   logic                        bit_end;

   assign bit_end = (div_cnt == $bits(div_cnt)'(UART_DIV - 1));
   assign tx      = shift[0];

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         shift   <= '1;  // idle line high
         bit_cnt <= '0;
         div_cnt <= '0;
         busy    <= 1'b0;
      end else if (!busy) begin
         if (wr_en) begin
            shift   <= {1'b1, wr_data, 1'b0};  // stop, data, start
            bit_cnt <= '0;
            div_cnt <= '0;
            busy    <= 1'b1;
         end
      end else begin
         div_cnt <= div_cnt + 1'b1;
         if (bit_end) begin
            div_cnt <= '0;
            shift   <= {1'b1, shift[9:1]};
            if (bit_cnt == 4'd9)
               busy <= 1'b0;  // end of stop bit
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

endmodule

//--- hw/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric
   import bus_pkg::*;
   import sysctl_pkg::*;
(
   input  logic        sys_clk,
   input  logic        reset_n,
   input  logic        req_valid,
   input  bus_req_t    req,
   output logic        req_ready,
   output logic        rsp_valid,
   output bus_rsp_t    rsp,
   output logic        reg_strobe,
   output reg_access_t reg_acc,
   input  logic [7:0]  reg_rd_data
);

   logic [7:0] ram [2**RAM_AW];
   logic [7:0] ram_q;
   logic       rd_pend;
   logic       sel_ram;
   logic       sel_reg;
   logic       accept;
   logic       hit_ram;
   logic       hit_reg;

   assign hit_ram = (req.addr <= RAM_TOP);
   assign hit_reg = (req.addr[15:8] == SYS_PAGE);

   assign req_ready  = ~rd_pend;  // one-cycle gap per read
   assign accept     = req_valid & req_ready;
   assign reg_strobe = accept & hit_reg;
   assign reg_acc    = '{offset: req.addr[7:0], wdata: req.wdata, wr: req.wr};

   always_ff @(posedge sys_clk) begin
      if (accept && hit_ram) begin
         if (req.wr)
            ram[req.addr[RAM_AW-1:0]] <= req.wdata;
         ram_q <= ram[req.addr[RAM_AW-1:0]];
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         rd_pend <= 1'b0;
         sel_ram <= 1'b0;
         sel_reg <= 1'b0;
      end else begin
         rd_pend <= accept & ~req.wr;
         if (accept) begin
            sel_ram <= hit_ram;
            sel_reg <= hit_reg;
         end
      end
   end

   assign rsp_valid = rd_pend;

   always_comb begin
      if (sel_ram)
         rsp.data = ram_q;
      else if (sel_reg)
         rsp.data = reg_rd_data;
      else
         rsp.data = UNMAPPED_DATA;
   end

endmodule

//--- hw/sys_regs.sv
`timescale 1ns/1ps

module sys_regs
   import sysctl_pkg::*;
(
   input  logic        sys_clk,
   input  logic        reset_n,
   input  logic        reg_strobe,
   input  reg_access_t reg_acc,
   output logic [7:0]  reg_rd_data,
   output logic        irq_n,
   output logic        cpu_clk_en,
   output logic        uart_tx
);

   logic [2:0]              speed;
   logic [2:0]              timer_idx;
   timer_val_t              ticks [NUM_TIMERS];
   timer_val_t              value [NUM_TIMERS];
   logic [NUM_TIMERS-1:0]   timer_en;
   logic [NUM_TIMERS-1:0]   timer_load;
   logic [NUM_TIMERS-1:0]   timer_ack;
   logic [NUM_TIMERS-1:0]   timer_irq;
   logic [7:0]              irq_byte;
   logic                    wr_strobe;
   logic                    uart_busy;

   assign wr_strobe = reg_strobe & reg_acc.wr;

   // timer 0 lands in bit 7
   always_comb begin
      for (int i = 0; i < NUM_TIMERS; i++)
         irq_byte[NUM_TIMERS-1-i] = timer_irq[i];
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         speed      <= '0;
         timer_idx  <= '0;
         timer_en   <= '0;
         timer_load <= '0;
         timer_ack  <= '0;
         irq_n      <= 1'b1;
         for (int i = 0; i < NUM_TIMERS; i++)
            ticks[i] <= '0;
      end else begin
         timer_load <= '0;  // single-cycle pulses
         timer_ack  <= '0;
         irq_n      <= ~|timer_irq;
         if (wr_strobe) begin
            case (reg_acc.offset)
               REG_SPEED:      speed <= reg_acc.wdata[2:0];
               REG_TIMER_IDX:  timer_idx <= reg_acc.wdata[2:0];
               REG_TICKS_LO:   ticks[timer_idx][7:0] <= reg_acc.wdata;
               REG_TICKS_MID:  ticks[timer_idx][15:8] <= reg_acc.wdata;
               REG_TICKS_HI:   ticks[timer_idx][19:16] <= reg_acc.wdata[3:0];
               REG_TIMER_LOAD: timer_load[timer_idx] <= 1'b1;
               REG_TIMER_EN:   timer_en[timer_idx] <= reg_acc.wdata[0];
               REG_IRQ:        timer_ack[timer_idx] <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (reg_strobe && !reg_acc.wr) begin
         case (reg_acc.offset)
            REG_SPEED:     reg_rd_data <= {5'b0, speed};
            REG_TIMER_IDX: reg_rd_data <= {5'b0, timer_idx};
            REG_TICKS_LO:  reg_rd_data <= value[timer_idx][7:0];
            REG_TICKS_MID: reg_rd_data <= value[timer_idx][15:8];
            REG_TICKS_HI:  reg_rd_data <= {4'b0, value[timer_idx][19:16]};
            REG_TIMER_EN:  reg_rd_data <= {7'b0, timer_en[timer_idx]};
            REG_IRQ:       reg_rd_data <= irq_byte;
            REG_STATUS:    reg_rd_data <= {6'b0, uart_busy, 1'b0};  // no receiver
            default:       reg_rd_data <= 8'h00;
         endcase
      end
   end

   for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
      interval_timer timer_inst (
         .sys_clk   (sys_clk),
         .reset_n   (reset_n),
         .enable    (timer_en[i]),
         .load      (timer_load[i]),
         .ack       (timer_ack[i]),
         .max_ticks (ticks[i]),
         .value     (value[i]),
         .irq       (timer_irq[i])
      );
   end

   clk_throttle throttle_inst (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .speed   (speed),
      .clk_en  (cpu_clk_en)
   );

   uart_tx uart_tx_inst (
      .sys_clk (sys_clk),
      .reset_n (reset_n),
      .wr_en   (wr_strobe && reg_acc.offset == REG_UART_DATA),
      .wr_data (reg_acc.wdata),
      .busy    (uart_busy),
      .tx      (uart_tx)
   );

endmodule

//--- hw/sys_top.sv
`timescale 1ns/1ps

module sys_top
   import bus_pkg::*;
   import sysctl_pkg::*;
(
   input  logic     sys_clk,
   input  logic     reset_n,
   input  logic     req_valid,
   input  bus_req_t req,
   output logic     req_ready,
   output logic     rsp_valid,
   output bus_rsp_t rsp,
   output logic     irq_n,
   output logic     cpu_clk_en,
   output logic     uart_tx
);

   logic        reg_strobe;
   reg_access_t reg_acc;
   logic [7:0]  reg_rd_data;

   bus_fabric fabric_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .req_valid   (req_valid),
      .req         (req),
      .req_ready   (req_ready),
      .rsp_valid   (rsp_valid),
      .rsp         (rsp),
      .reg_strobe  (reg_strobe),
      .reg_acc     (reg_acc),
      .reg_rd_data (reg_rd_data)
   );

   sys_regs regs_inst (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .reg_strobe  (reg_strobe),
      .reg_acc     (reg_acc),
      .reg_rd_data (reg_rd_data),
      .irq_n       (irq_n),
      .cpu_clk_en  (cpu_clk_en),
      .uart_tx     (uart_tx)
   );

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic sys_clk,
   output logic reset_n
);

   initial begin
      sys_clk = 1'b0;
      forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
   end

   initial begin
      reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge sys_clk);
      reset_n <= 1'b1;  // released on an edge, like the sync reset expects
   end

endmodule

//--- dv/sys_top_sva.sv
`timescale 1ns/1ps

module sys_top_sva
   import bus_pkg::*;
(
   input logic     sys_clk,
   input logic     reset_n,
   input logic     req_valid,
   input bus_req_t req,
   input logic     req_ready,
   input logic     rsp_valid
);

   int   fail_count = 0;
   logic rd_accept;

   assign rd_accept = req_valid && req_ready && !req.wr;

   rsp_after_read: assert property (@(posedge sys_clk) disable iff (!reset_n)
      rsp_valid |-> $past(rd_accept))
   else begin
      fail_count++;
      $error("rsp_valid without a read accepted on the previous edge");
   end

   // ready drops only for the response cycle
   ready_gap: assert property (@(posedge sys_clk) disable iff (!reset_n)
      req_ready == !$past(rd_accept))
   else begin
      fail_count++;
      $error("req_ready is not low exactly in the cycle after a read accept");
   end

   rsp_in_reset: assert property (@(posedge sys_clk) !reset_n |=> !rsp_valid)
   else begin
      fail_count++;
      $error("rsp_valid high while in reset");
   end

endmodule

bind sys_top sys_top_sva sva_inst (
   .sys_clk   (sys_clk),
   .reset_n   (reset_n),
   .req_valid (req_valid),
   .req       (req),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid)
);

//--- dv/sys_top_tb.sv
`timescale 1ns/1ps

module sys_top_tb
   import bus_pkg::*;
   import sysctl_pkg::*;
();

   localparam int SEED       = 80058;
   localparam int CLK_NS     = 20;
   localparam int NUM_RAM    = 16;
   localparam int RESP_LIMIT = 8;
   localparam int RAM_CYC    = (NUM_RAM + 4) * 6;  // write plus read per address
   localparam int REG_CYC    = 60;
   localparam int TIMER_CYC  = 60 + 60;
   localparam int THROT_CYC  = 6 * (32 + 64 + 4);
   localparam int UART_CYC   = 11 * UART_DIV + 20;
   localparam int WDOG_CYC   = 10 + RAM_CYC + REG_CYC + TIMER_CYC + THROT_CYC + UART_CYC + 200;

   logic     sys_clk;
   logic     reset_n;
   logic     req_valid;
   bus_req_t req;
   logic     req_ready;
   logic     rsp_valid;
   bus_rsp_t rsp;
   logic     irq_n;
   logic     cpu_clk_en;
   logic     uart_tx;
   int       value_errs = 0;
   int       proto_errs = 0;
   int       sva_errs;

   tb_clkgen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) clkgen_inst (
      .sys_clk (sys_clk),
      .reset_n (reset_n)
   );

   sys_top sys_top_inst (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .irq_n      (irq_n),
      .cpu_clk_en (cpu_clk_en),
      .uart_tx    (uart_tx)
   );

   function automatic logic [15:0] page_addr(input logic [7:0] offset);
      return {SYS_PAGE, offset};
   endfunction

   task automatic cmp_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %0t %s expected %h actual %h", $time, name, exp.data, act.data);
      end
   endtask

   task automatic cmp_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         value_errs++;
         $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   task automatic cmp_ticks_below(input string name, input timer_val_t limit,
                                  input timer_val_t act);
      if (act >= limit) begin
         value_errs++;
         $display("Fail %0t %s expected below %h actual %h", $time, name, limit, act);
      end
   endtask

   task automatic cmp_count(input string name, input int exp, input int act);
      if (act != exp) begin
         value_errs++;
         $display("Fail %0t %s expected %0d actual %0d", $time, name, exp, act);
      end
   endtask

   // returns on the edge where the request transfers
   task automatic wait_accept();
      int waited;
      waited = 0;
      @(negedge sys_clk);
      while (!req_ready && waited < RESP_LIMIT) begin
         waited++;
         @(negedge sys_clk);
      end
      if (!req_ready) begin
         proto_errs++;
         $display("request held off by req_ready for too long at %0t", $time);
      end
      @(posedge sys_clk);
      req_valid <= 1'b0;
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge sys_clk);
      req_valid <= 1'b1;
      req       <= '{addr: addr, wdata: data, wr: 1'b1};
      wait_accept();
   endtask

   task automatic bus_read(input logic [15:0] addr, output bus_rsp_t data);
      int waited;
      @(posedge sys_clk);
      req_valid <= 1'b1;
      req       <= '{addr: addr, wdata: 8'h00, wr: 1'b0};
      wait_accept();
      waited = 1;
      @(negedge sys_clk);
      while (!rsp_valid && waited < RESP_LIMIT) begin
         waited++;
         @(negedge sys_clk);
      end
      if (!rsp_valid) begin
         proto_errs++;
         $display("no read response for address %h at %0t", addr, $time);
      end else if (waited != 1) begin
         proto_errs++;
         $display("read response for %h came %0d cycles after accept", addr, waited);
      end
      data = rsp;
   endtask

   task automatic read_check(input string name, input logic [15:0] addr, input logic [7:0] exp);
      bus_rsp_t got;
      bus_read(addr, got);
      cmp_rsp(name, bus_rsp_t'(exp), got);
   endtask

   task automatic test_ram_decode();
      logic [15:0] addrs [NUM_RAM];
      logic [7:0]  data  [NUM_RAM];
      for (int i = 0; i < NUM_RAM; i++) begin
         addrs[i] = {4'h0, 4'(i), 8'($urandom())};  // one address per 256-byte block
         data[i]  = 8'($urandom());
         bus_write(addrs[i], data[i]);
      end
      for (int i = 0; i < NUM_RAM; i++)
         read_check("ram rsp", addrs[i], data[i]);
      bus_write(RAM_TOP, 8'hA5);
      read_check("ram top rsp", RAM_TOP, 8'hA5);
      read_check("unmapped rsp", 16'h1000, UNMAPPED_DATA);
      read_check("unmapped rsp", 16'h5000, UNMAPPED_DATA);
   endtask

   task automatic test_reg_readback();
      bus_write(page_addr(REG_SPEED), 8'h03);
      read_check("speed", page_addr(REG_SPEED), 8'h03);
      bus_write(page_addr(REG_SPEED), 8'h00);
      bus_write(page_addr(REG_TIMER_IDX), 8'h05);
      read_check("timer idx", page_addr(REG_TIMER_IDX), 8'h05);
      bus_write(page_addr(REG_TIMER_EN), 8'h01);
      read_check("timer en", page_addr(REG_TIMER_EN), 8'h01);
      bus_write(page_addr(REG_TIMER_EN), 8'h00);
      read_check("timer en", page_addr(REG_TIMER_EN), 8'h00);
      read_check("irq byte", page_addr(REG_IRQ), 8'h04);  // timer 5 wrapped at max 0
      bus_write(page_addr(REG_IRQ), 8'h00);
      repeat (2) @(posedge sys_clk);
      @(negedge sys_clk);
      cmp_bit("irq_n", 1'b1, irq_n);
   endtask

   task automatic test_timer_irq();
      timer_val_t count;
      bus_rsp_t   lo;
      bus_rsp_t   mid;
      bus_rsp_t   hi;
      bus_write(page_addr(REG_TIMER_IDX), 8'h03);
      bus_write(page_addr(REG_TICKS_LO), 8'd20);
      bus_write(page_addr(REG_TICKS_MID), 8'h00);
      bus_write(page_addr(REG_TICKS_HI), 8'h00);
      bus_write(page_addr(REG_TIMER_LOAD), 8'h00);
      bus_write(page_addr(REG_TIMER_EN), 8'h01);
      repeat (60) @(posedge sys_clk);
      read_check("irq byte", page_addr(REG_IRQ), 8'h10);  // timer 3 in bit 4
      cmp_bit("irq_n", 1'b0, irq_n);
      bus_write(page_addr(REG_IRQ), 8'h00);
      repeat (2) @(posedge sys_clk);
      @(negedge sys_clk);
      cmp_bit("irq_n", 1'b1, irq_n);
      read_check("irq byte", page_addr(REG_IRQ), 8'h00);
      bus_read(page_addr(REG_TICKS_LO), lo);
      bus_read(page_addr(REG_TICKS_MID), mid);
      bus_read(page_addr(REG_TICKS_HI), hi);
      count = {hi.data[3:0], mid.data, lo.data};
      cmp_ticks_below("timer 3 count", 20'd21, count);
      bus_write(page_addr(REG_TIMER_EN), 8'h00);
   endtask

   task automatic test_throttle();
      int pulses;
      for (int s = 0; s <= 5; s++) begin
         bus_write(page_addr(REG_SPEED), 8'(s));
         repeat (32) @(posedge sys_clk);  // let the old period run out
         pulses = 0;
         repeat (64) begin
            @(negedge sys_clk);
            if (cpu_clk_en)
               pulses++;
         end
         cmp_count("cpu_clk_en pulses", 64 >> ((s < 5) ? s : 5), pulses);
      end
   endtask

   task automatic sample_frame(input logic [7:0] exp_byte);
      int waited;
      waited = 0;
      @(negedge sys_clk);
      while (uart_tx && waited < 4 * UART_DIV) begin
         waited++;
         @(negedge sys_clk);
      end
      if (uart_tx) begin
         proto_errs++;
         $display("uart_tx never dropped for the start bit at %0t", $time);
      end
      repeat (UART_DIV / 2) @(negedge sys_clk);  // centre of start bit
      cmp_bit("uart start bit", 1'b0, uart_tx);
      for (int i = 0; i < 8; i++) begin
         repeat (UART_DIV) @(negedge sys_clk);
         cmp_bit($sformatf("uart data bit %0d", i), exp_byte[i], uart_tx);
      end
      repeat (UART_DIV) @(negedge sys_clk);
      cmp_bit("uart stop bit", 1'b1, uart_tx);
   endtask

   task automatic test_uart();
      logic [7:0] tx_byte;
      tx_byte = 8'($urandom());
      bus_write(page_addr(REG_UART_DATA), tx_byte);
      fork
         sample_frame(tx_byte);
         read_check("status busy", page_addr(REG_STATUS), 8'h02);
      join
      repeat (UART_DIV) @(posedge sys_clk);
      read_check("status idle", page_addr(REG_STATUS), 8'h00);
      cmp_bit("uart_tx idle", 1'b1, uart_tx);
   endtask

   initial begin
      void'($urandom(SEED));
      req_valid = 1'b0;
      req       = '0;
      wait (reset_n === 1'b1);
      @(negedge sys_clk);
      cmp_bit("req_ready", 1'b1, req_ready);
      cmp_bit("rsp_valid", 1'b0, rsp_valid);
      cmp_bit("irq_n", 1'b1, irq_n);
      cmp_bit("uart_tx", 1'b1, uart_tx);
      cmp_bit("cpu_clk_en", 1'b1, cpu_clk_en);
      test_ram_decode();
      test_reg_readback();
      test_timer_irq();
      test_throttle();
      test_uart();
      sva_errs = sys_top_inst.sva_inst.fail_count;
      $display("errors: %0d value, %0d protocol, %0d assertion",
               value_errs, proto_errs, sva_errs);
      if (value_errs + proto_errs + sva_errs == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      repeat (WDOG_CYC) @(posedge sys_clk);
      $display("watchdog expired after %0d cycles, tests did not finish", WDOG_CYC);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- flist.f
hw/bus_pkg.sv
hw/sysctl_pkg.sv
hw/interval_timer.sv
hw/clk_throttle.sv
hw/uart_tx.sv
hw/bus_fabric.sv
hw/sys_regs.sv
hw/sys_top.sv
dv/tb_clkgen.sv
dv/sys_top_sva.sv
dv/sys_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := sys_top_tb
FLIST     := flist.f
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
